//--- src/ulpi_pkg.sv
`default_nettype none

package ulpi_pkg;

  // Bus width and the split of a PID byte into type and check nibbles
  localparam int ULPI_DATA_W  = 8;
  localparam int PID_NIBBLE_W = 4;

  typedef logic [ULPI_DATA_W-1:0] ulpi_byte_t;

  // Driven by the link during the stp cycle, never a valid PID
  localparam ulpi_byte_t ULPI_IDLE_BYTE = 8'h00;

  // Link transmit engine
  typedef enum logic [1:0] {
    TX_IDLE = 2'd0,
    TX_SEND = 2'd1,
    TX_STOP = 2'd2
  } ulpi_tx_state_e;

  // PHY model, SEND drives the bus and RECV captures link data
  typedef enum logic [1:0] {
    PHY_IDLE = 2'd0,
    PHY_SEND = 2'd1,
    PHY_RECV = 2'd2
  } ulpi_phy_state_e;

  // A PID carries its own type inverted in the upper nibble.
  // Two-state result so an undriven bus never looks like a start
  function automatic bit pid_is_valid(input ulpi_byte_t b);
    return b[PID_NIBBLE_W-1:0] == ~b[ULPI_DATA_W-1:PID_NIBBLE_W];
  endfunction

endpackage

`default_nettype wire

//--- src/ulpi_link_tx.sv
`timescale 1ns/1ps
`default_nettype none

module ulpi_link_tx
  import ulpi_pkg::*;
(
  input  wire             clock,
  input  wire             reset_i,

  // User transmit stream
  input  wire             tx_tvalid_i,
  input  wire             tx_tlast_i,
  input  wire ulpi_byte_t tx_tdata_i,
  output logic            tx_tready_o,

  // ULPI link-side signals
  input  wire             ulpi_dir_i,
  input  wire             ulpi_nxt_i,
  output logic            ulpi_stp_o,
  output logic            ulpi_rst_no,
  output ulpi_byte_t      ulpi_data_o,
  output logic            ulpi_data_oe_o
);

  ulpi_tx_state_e state_q;
  logic           rst_n_q;
  logic           accept;

  // PHY reset follows the system reset one cycle later
  always_ff @(posedge clock) begin
    rst_n_q <= !reset_i;
  end

  assign ulpi_rst_no = rst_n_q;

  // Bus ownership and byte handshake
  always_comb begin
    tx_tready_o    = 1'b0;
    ulpi_data_oe_o = 1'b0;
    ulpi_data_o    = tx_tdata_i;
    case (state_q)
      TX_IDLE: begin
        // PID goes out as soon as the bus is ours, held until nxt
        ulpi_data_oe_o = tx_tvalid_i && !ulpi_dir_i;
        tx_tready_o    = ulpi_nxt_i && !ulpi_dir_i;
      end
      TX_SEND: begin
        ulpi_data_oe_o = 1'b1;
        tx_tready_o    = ulpi_nxt_i;
      end
      TX_STOP: begin
        ulpi_data_oe_o = 1'b1;
        ulpi_data_o    = ULPI_IDLE_BYTE;
      end
      default: begin
        ulpi_data_oe_o = 1'b0;
      end
    endcase
  end

  assign accept     = tx_tvalid_i && tx_tready_o;
  assign ulpi_stp_o = (state_q == TX_STOP);

  always_ff @(posedge clock) begin
    if (reset_i) begin
      state_q <= TX_IDLE;
    end else begin
      case (state_q)
        TX_IDLE, TX_SEND: begin
          if (accept) begin
            // Last byte taken, close the packet with one stp cycle
            state_q <= tx_tlast_i ? TX_STOP : TX_SEND;
          end
        end
        TX_STOP: begin
          state_q <= TX_IDLE;
        end
        default: begin
          state_q <= TX_IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- src/ulpi_link_rx.sv
`timescale 1ns/1ps
`default_nettype none

module ulpi_link_rx
  import ulpi_pkg::*;
#(
  parameter int MAX_PACKET_BYTES = 64
) (
  input  wire             clock,
  input  wire             reset_i,

  input  wire             ulpi_dir_i,
  input  wire             ulpi_nxt_i,
  input  wire ulpi_byte_t ulpi_data_i,

  output logic            rx_tvalid_o,
  output logic            rx_tlast_o,
  output ulpi_byte_t      rx_tdata_o,
  output logic            rx_error_o
);

  localparam int CNT_W = $clog2(MAX_PACKET_BYTES + 1);

  ulpi_byte_t       hold_q;
  logic             hold_valid_q;
  logic             drop_q;
  logic [CNT_W-1:0] count_q;
  logic             capture;
  logic             overrun;
  logic             emit;

  assign capture = ulpi_dir_i && ulpi_nxt_i && !drop_q;
  assign overrun = capture && (count_q == CNT_W'(MAX_PACKET_BYTES));
  // Held byte leaves on the next byte or when the PHY gives the bus back
  assign emit    = hold_valid_q && (capture || !ulpi_dir_i);

  always_ff @(posedge clock) begin
    if (reset_i) begin
      hold_valid_q <= 1'b0;
      drop_q       <= 1'b0;
      count_q      <= '0;
      rx_tvalid_o  <= 1'b0;
      rx_tlast_o   <= 1'b0;
      rx_error_o   <= 1'b0;
    end else begin
      rx_tvalid_o <= emit;
      rx_tlast_o  <= emit && !ulpi_dir_i;
      rx_error_o  <= overrun;
      if (!ulpi_dir_i) begin
        hold_valid_q <= 1'b0;
        drop_q       <= 1'b0;
        count_q      <= '0;
      end else if (overrun) begin
        // Too long, the rest of the packet is thrown away
        hold_valid_q <= 1'b0;
        drop_q       <= 1'b1;
      end else if (capture) begin
        hold_valid_q <= 1'b1;
        count_q      <= count_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (capture && !overrun) begin
      hold_q <= ulpi_data_i;
    end
    if (emit) begin
      rx_tdata_o <= hold_q;
    end
  end

endmodule

`default_nettype wire

//--- src/ulpi_phy_model.sv
`timescale 1ns/1ps
`default_nettype none

module ulpi_phy_model
  import ulpi_pkg::*;
(
  input  wire             clock,
  input  wire             reset_i,

  // ULPI PHY-side signals
  input  wire             ulpi_rst_ni,
  input  wire             ulpi_stp_i,
  input  wire ulpi_byte_t ulpi_data_i,
  output logic            ulpi_dir_o,
  output logic            ulpi_nxt_o,
  output ulpi_byte_t      ulpi_data_o,

  // USB side, packets coming in from the cable
  input  wire             usb_in_tvalid_i,
  input  wire             usb_in_tlast_i,
  input  wire ulpi_byte_t usb_in_tdata_i,
  output logic            usb_in_tready_o,

  // USB side, packets going out to the cable
  output logic            usb_out_tvalid_o,
  output logic            usb_out_tlast_o,
  output ulpi_byte_t      usb_out_tdata_o,
  input  wire             usb_out_tready_i
);

  ulpi_phy_state_e state_q;
  logic            dir_q;
  logic            nxt_q;
  logic            last_q;
  ulpi_byte_t      dat_q;
  logic            out_valid_q;
  ulpi_byte_t      out_data_q;
  logic            link_start;
  logic            usb_start;
  logic            phy_reset;

  assign phy_reset = reset_i || !ulpi_rst_ni;

  // Link owns an idle bus when it shows a PID, and that beats USB input
  assign link_start = !dir_q && pid_is_valid(ulpi_data_i) && usb_out_tready_i;
  assign usb_start  = usb_in_tvalid_i && !link_start;

  always_comb begin
    case (state_q)
      PHY_IDLE: usb_in_tready_o = usb_start;
      PHY_SEND: usb_in_tready_o = !last_q;
      default:  usb_in_tready_o = 1'b0;
    endcase
  end

  assign ulpi_dir_o  = dir_q;
  assign ulpi_nxt_o  = nxt_q;
  assign ulpi_data_o = dat_q;

  always_ff @(posedge clock) begin
    if (phy_reset) begin
      state_q <= PHY_IDLE;
      dir_q   <= 1'b0;
      nxt_q   <= 1'b0;
      last_q  <= 1'b0;
    end else begin
      case (state_q)
        PHY_IDLE: begin
          if (link_start) begin
            // One cycle pause on the PID, then nxt
            state_q <= PHY_RECV;
            nxt_q   <= 1'b1;
          end else if (usb_start) begin
            state_q <= PHY_SEND;
            dir_q   <= 1'b1;
            nxt_q   <= 1'b1;
            last_q  <= usb_in_tlast_i;
          end
        end
        PHY_SEND: begin
          if (last_q) begin
            state_q <= PHY_IDLE;
            dir_q   <= 1'b0;
            nxt_q   <= 1'b0;
            last_q  <= 1'b0;
          end else begin
            // A gap in the input shows up as nxt low with dir held
            nxt_q  <= usb_in_tvalid_i;
            last_q <= usb_in_tvalid_i && usb_in_tlast_i;
          end
        end
        PHY_RECV: begin
          if (ulpi_stp_i) begin
            state_q <= PHY_IDLE;
            nxt_q   <= 1'b0;
          end
        end
        default: begin
          state_q <= PHY_IDLE;
        end
      endcase
    end
  end

  // Bytes the link put on the bus while nxt was high, minus the stp byte
  always_ff @(posedge clock) begin
    if (phy_reset) begin
      out_valid_q <= 1'b0;
    end else begin
      out_valid_q <= (state_q == PHY_RECV) && nxt_q && !ulpi_stp_i;
    end
  end

  always_ff @(posedge clock) begin
    if (usb_in_tvalid_i && usb_in_tready_o) begin
      dat_q <= usb_in_tdata_i;
    end
    out_data_q <= ulpi_data_i;
  end

  assign usb_out_tvalid_o = out_valid_q;
  assign usb_out_tdata_o  = out_data_q;
  // stp arrives in the same cycle that the last captured byte is shown
  assign usb_out_tlast_o  = out_valid_q && ulpi_stp_i;

endmodule

`default_nettype wire

//--- src/ulpi_link_top.sv
`timescale 1ns/1ps
`default_nettype none

module ulpi_link_top
  import ulpi_pkg::*;
#(
  parameter int MAX_PACKET_BYTES = 64
) (
  input  wire             clock,
  input  wire             reset_i,

  // User transmit stream
  input  wire             tx_tvalid_i,
  input  wire             tx_tlast_i,
  input  wire ulpi_byte_t tx_tdata_i,
  output logic            tx_tready_o,

  // User receive stream
  output logic            rx_tvalid_o,
  output logic            rx_tlast_o,
  output ulpi_byte_t      rx_tdata_o,
  output logic            rx_error_o,

  // USB cable side
  input  wire             usb_in_tvalid_i,
  input  wire             usb_in_tlast_i,
  input  wire ulpi_byte_t usb_in_tdata_i,
  output logic            usb_in_tready_o,
  output logic            usb_out_tvalid_o,
  output logic            usb_out_tlast_o,
  output ulpi_byte_t      usb_out_tdata_o,
  input  wire             usb_out_tready_i
);

  logic       ulpi_dir;
  logic       ulpi_nxt;
  logic       ulpi_stp;
  logic       ulpi_rst_n;
  logic       link_data_oe;
  ulpi_byte_t link_data;
  ulpi_byte_t phy_data;
  wire  ulpi_byte_t ulpi_data;

  // Shared data bus, the link drives it while dir is low
  assign ulpi_data = link_data_oe ? link_data : 'z;
  assign ulpi_data = ulpi_dir ? phy_data : 'z;

  ulpi_link_tx i_ulpi_link_tx (
    .clock          (clock),
    .reset_i        (reset_i),
    .tx_tvalid_i    (tx_tvalid_i),
    .tx_tlast_i     (tx_tlast_i),
    .tx_tdata_i     (tx_tdata_i),
    .tx_tready_o    (tx_tready_o),
    .ulpi_dir_i     (ulpi_dir),
    .ulpi_nxt_i     (ulpi_nxt),
    .ulpi_stp_o     (ulpi_stp),
    .ulpi_rst_no    (ulpi_rst_n),
    .ulpi_data_o    (link_data),
    .ulpi_data_oe_o (link_data_oe)
  );

  ulpi_link_rx #(
    .MAX_PACKET_BYTES (MAX_PACKET_BYTES)
  ) i_ulpi_link_rx (
    .clock       (clock),
    .reset_i     (reset_i),
    .ulpi_dir_i  (ulpi_dir),
    .ulpi_nxt_i  (ulpi_nxt),
    .ulpi_data_i (ulpi_data),
    .rx_tvalid_o (rx_tvalid_o),
    .rx_tlast_o  (rx_tlast_o),
    .rx_tdata_o  (rx_tdata_o),
    .rx_error_o  (rx_error_o)
  );

  ulpi_phy_model i_ulpi_phy_model (
    .clock            (clock),
    .reset_i          (reset_i),
    .ulpi_rst_ni      (ulpi_rst_n),
    .ulpi_stp_i       (ulpi_stp),
    .ulpi_data_i      (ulpi_data),
    .ulpi_dir_o       (ulpi_dir),
    .ulpi_nxt_o       (ulpi_nxt),
    .ulpi_data_o      (phy_data),
    .usb_in_tvalid_i  (usb_in_tvalid_i),
    .usb_in_tlast_i   (usb_in_tlast_i),
    .usb_in_tdata_i   (usb_in_tdata_i),
    .usb_in_tready_o  (usb_in_tready_o),
    .usb_out_tvalid_o (usb_out_tvalid_o),
    .usb_out_tlast_o  (usb_out_tlast_o),
    .usb_out_tdata_o  (usb_out_tdata_o),
    .usb_out_tready_i (usb_out_tready_i)
  );

endmodule

`default_nettype wire

//--- tb/ulpi_link_properties.sv
`timescale 1ns/1ps
`default_nettype none

module ulpi_link_properties
  import ulpi_pkg::*;
(
  input wire                  clock,
  input wire                  reset_i,
  input wire ulpi_phy_state_e state_i,
  input wire                  dir_i,
  input wire                  nxt_i,
  input wire                  stp_i,
  input wire ulpi_byte_t      bus_i,
  input wire ulpi_byte_t      phy_data_i
);

  int fail_count = 0;

  nxt_low_in_idle: assert property (
    @(posedge clock) disable iff (reset_i) (state_i == PHY_IDLE) |-> !nxt_i
  ) else begin
    $error("nxt high while the PHY is idle");
    fail_count++;
  end

  no_stp_with_dir: assert property (
    @(posedge clock) disable iff (reset_i) $rose(stp_i) |-> !dir_i
  ) else begin
    $error("stp rose while the PHY owns the bus");
    fail_count++;
  end

  // With dir high only the PHY byte may be on the bus, any link drive shows up here
  single_bus_driver: assert property (
    @(posedge clock) disable iff (reset_i) dir_i |-> (bus_i === phy_data_i)
  ) else begin
    $error("link and PHY drive the data bus together");
    fail_count++;
  end

endmodule

bind ulpi_phy_model ulpi_link_properties i_ulpi_link_properties (
  .clock      (clock),
  .reset_i    (reset_i),
  .state_i    (state_q),
  .dir_i      (ulpi_dir_o),
  .nxt_i      (ulpi_nxt_o),
  .stp_i      (ulpi_stp_i),
  .bus_i      (ulpi_data_i),
  .phy_data_i (ulpi_data_o)
);

`default_nettype wire

//--- tb/ulpi_link_tb.sv
`timescale 1ns/1ps
`default_nettype none

module ulpi_link_tb
  import ulpi_pkg::*;
();

  localparam int MAX_PACKET_BYTES = 64;
  localparam int MAX_LEN          = 16;
  localparam int MAX_GAP          = 7;
  localparam int NUM_PACKETS      = 40;
  localparam int NUM_GATED        = 10;
  localparam int NUM_COLLIDE      = 20;
  localparam int TOTAL_BYTES      = (2 * NUM_PACKETS + NUM_GATED + 2 * NUM_COLLIDE) * MAX_LEN
                                    + MAX_PACKET_BYTES + 4 + MAX_LEN;
  localparam int TOTAL_GAPS       = (2 * NUM_PACKETS + 2 * NUM_GATED + NUM_COLLIDE + 2) * MAX_GAP
                                    + 40;
  localparam int TIMEOUT_CYCLES   = 4 * (TOTAL_BYTES + TOTAL_GAPS) + 200;

  logic       clock, reset_i;
  logic       tx_tvalid_i, tx_tlast_i, tx_tready_o;
  ulpi_byte_t tx_tdata_i;
  logic       rx_tvalid_o, rx_tlast_o, rx_error_o;
  ulpi_byte_t rx_tdata_o;
  logic       usb_in_tvalid_i, usb_in_tlast_i, usb_in_tready_o;
  ulpi_byte_t usb_in_tdata_i;
  logic       usb_out_tvalid_o, usb_out_tlast_o, usb_out_tready_i;
  ulpi_byte_t usb_out_tdata_o;

  integer     seed;
  int         cycle = 0;
  int         errors = 0;
  int         checks = 0;
  int         out_packets = 0;
  int         rx_packets = 0;
  int         rx_errors = 0;
  int         usb_first_accept, out_last_cycle;
  int         mark, base, base_err;
  logic [8:0] out_exp, rx_exp;

  // Packet buffers and expected {last, data} per direction
  ulpi_byte_t pkt_buf[$:MAX_PACKET_BYTES+4];
  ulpi_byte_t tx_pkt[$:MAX_PACKET_BYTES+4];
  ulpi_byte_t usb_pkt[$:MAX_PACKET_BYTES+4];
  logic [8:0] exp_out[$:2*MAX_PACKET_BYTES];
  logic [8:0] exp_rx[$:2*MAX_PACKET_BYTES];
  int         last_cycle_q[$];

  ulpi_link_top #(
    .MAX_PACKET_BYTES (MAX_PACKET_BYTES)
  ) i_ulpi_link_top (
    .clock            (clock),
    .reset_i          (reset_i),
    .tx_tvalid_i      (tx_tvalid_i),
    .tx_tlast_i       (tx_tlast_i),
    .tx_tdata_i       (tx_tdata_i),
    .tx_tready_o      (tx_tready_o),
    .rx_tvalid_o      (rx_tvalid_o),
    .rx_tlast_o       (rx_tlast_o),
    .rx_tdata_o       (rx_tdata_o),
    .rx_error_o       (rx_error_o),
    .usb_in_tvalid_i  (usb_in_tvalid_i),
    .usb_in_tlast_i   (usb_in_tlast_i),
    .usb_in_tdata_i   (usb_in_tdata_i),
    .usb_in_tready_o  (usb_in_tready_o),
    .usb_out_tvalid_o (usb_out_tvalid_o),
    .usb_out_tlast_o  (usb_out_tlast_o),
    .usb_out_tdata_o  (usb_out_tdata_o),
    .usb_out_tready_i (usb_out_tready_i)
  );

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  always @(posedge clock) begin
    cycle <= cycle + 1;
  end

  initial begin
    while (cycle < TIMEOUT_CYCLES) @(posedge clock);
    $display("ERROR: run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("SIMULATION FAILED");
    $finish;
  end

  function automatic int rand_range(input int lo, input int hi);
    int r;
    r = $random(seed);
    return lo + int'($unsigned(r) % (hi - lo + 1));
  endfunction

  // First byte is any byte that passes the PID check, the rest are random
  task automatic build_packet(input int len);
    ulpi_byte_t b;
    int         i;
    pkt_buf.delete();
    do begin
      b = ulpi_byte_t'($random(seed));
    end while (!pid_is_valid(b));
    pkt_buf.push_back(b);
    for (i = 1; i < len; i++) begin
      pkt_buf.push_back(ulpi_byte_t'($random(seed)));
    end
  endtask

  task automatic send_tx(input int gate);
    int i;
    for (i = 0; i < tx_pkt.size(); i++) begin
      exp_out.push_back({(i == tx_pkt.size() - 1), tx_pkt[i]});
    end
    tx_tvalid_i = 1'b1;
    for (i = 0; i < tx_pkt.size(); i++) begin
      tx_tdata_i = tx_pkt[i];
      tx_tlast_i = (i == tx_pkt.size() - 1);
      if (i == 0 && gate > 0) begin
        usb_out_tready_i = 1'b0;
        repeat (gate) begin
          @(negedge clock);
          checks++;
          assert (!tx_tready_o && !usb_out_tvalid_o) else begin
            $display("FAIL t=%0t tx_tready_o/usb_out_tvalid_o expected 0/0 got %b/%b",
                     $time, tx_tready_o, usb_out_tvalid_o);
            errors++;
          end
          @(posedge clock);
          #1;
        end
        usb_out_tready_i = 1'b1;
      end
      do @(negedge clock); while (!tx_tready_o);
      @(posedge clock);
      #1;
    end
    tx_tvalid_i = 1'b0;
    tx_tlast_i  = 1'b0;
  endtask

  // Bytes past MAX_PACKET_BYTES are dropped by the link and carry no last
  task automatic send_usb();
    int i;
    for (i = 0; i < usb_pkt.size() && i < MAX_PACKET_BYTES; i++) begin
      exp_rx.push_back({(i == usb_pkt.size() - 1), usb_pkt[i]});
    end
    usb_in_tvalid_i = 1'b1;
    for (i = 0; i < usb_pkt.size(); i++) begin
      usb_in_tdata_i = usb_pkt[i];
      usb_in_tlast_i = (i == usb_pkt.size() - 1);
      do @(negedge clock); while (!usb_in_tready_o);
      if (i == 0) begin
        usb_first_accept = cycle;
      end
      // Byte is on the bus one cycle later, last shows two cycles after that
      if (i == usb_pkt.size() - 1 && usb_pkt.size() <= MAX_PACKET_BYTES) begin
        last_cycle_q.push_back(cycle + 3);
      end
      @(posedge clock);
      #1;
    end
    usb_in_tvalid_i = 1'b0;
    usb_in_tlast_i  = 1'b0;
  endtask

  task automatic idle_gap();
    repeat (rand_range(0, MAX_GAP)) begin
      usb_out_tready_i = (rand_range(0, 1) != 0);
      @(posedge clock);
      #1;
    end
    usb_out_tready_i = 1'b1;
  endtask

  task automatic drain();
    while (exp_out.size() != 0 || exp_rx.size() != 0) @(negedge clock);
    repeat (4) @(posedge clock);
    #1;
  endtask

  task automatic check_count(input string what, input int expected, input int actual);
    checks++;
    assert (expected == actual) else begin
      $display("FAIL t=%0t %s expected %0d got %0d", $time, what, expected, actual);
      errors++;
    end
  endtask

  task automatic expect_low(input string name, input logic value);
    checks++;
    assert (value === 1'b0) else begin
      $display("FAIL t=%0t %s expected 0 got %b", $time, name, value);
      errors++;
    end
  endtask

  task automatic end_test(input string name, input int errors_before);
    $display("test %s: %s, %0d errors", name,
             (errors == errors_before) ? "ok" : "mismatch", errors - errors_before);
  endtask

  always @(negedge clock) begin
    if (usb_out_tvalid_o) begin
      checks++;
      assert (exp_out.size() > 0) else begin
        $display("ERROR t=%0t usb_out_tvalid_o high with no byte expected", $time);
        errors++;
      end
      if (exp_out.size() > 0) begin
        out_exp = exp_out.pop_front();
        assert (usb_out_tdata_o == out_exp[7:0]) else begin
          $display("FAIL t=%0t usb_out_tdata_o expected %h got %h",
                   $time, out_exp[7:0], usb_out_tdata_o);
          errors++;
        end
        assert (usb_out_tlast_o == out_exp[8]) else begin
          $display("FAIL t=%0t usb_out_tlast_o expected %b got %b",
                   $time, out_exp[8], usb_out_tlast_o);
          errors++;
        end
      end
      if (usb_out_tlast_o) begin
        out_packets++;
        out_last_cycle = cycle;
      end
    end
  end

  always @(negedge clock) begin
    if (rx_error_o) begin
      rx_errors++;
    end
    if (rx_tvalid_o) begin
      checks++;
      assert (exp_rx.size() > 0) else begin
        $display("ERROR t=%0t rx_tvalid_o high with no byte expected", $time);
        errors++;
      end
      if (exp_rx.size() > 0) begin
        rx_exp = exp_rx.pop_front();
        assert (rx_tdata_o == rx_exp[7:0]) else begin
          $display("FAIL t=%0t rx_tdata_o expected %h got %h", $time, rx_exp[7:0], rx_tdata_o);
          errors++;
        end
        assert (rx_tlast_o == rx_exp[8]) else begin
          $display("FAIL t=%0t rx_tlast_o expected %b got %b", $time, rx_exp[8], rx_tlast_o);
          errors++;
        end
      end
      if (rx_tlast_o && last_cycle_q.size() > 0) begin
        rx_packets++;
        check_count("rx_tlast_o cycle", last_cycle_q.pop_front(), cycle);
      end
    end
  end

  initial begin
    seed             = 87;
    reset_i          = 1'b1;
    tx_tvalid_i      = 1'b0;
    tx_tlast_i       = 1'b0;
    tx_tdata_i       = '0;
    usb_in_tvalid_i  = 1'b0;
    usb_in_tlast_i   = 1'b0;
    usb_in_tdata_i   = '0;
    usb_out_tready_i = 1'b1;
    repeat (16) @(posedge clock);
    #1;
    reset_i = 1'b0;
    // PHY reset trails the system reset by one cycle
    repeat (3) @(posedge clock);
    #1;

    mark = errors;
    expect_low("tx_tready_o", tx_tready_o);
    expect_low("rx_tvalid_o", rx_tvalid_o);
    expect_low("usb_in_tready_o", usb_in_tready_o);
    expect_low("usb_out_tvalid_o", usb_out_tvalid_o);
    expect_low("rx_error_o", rx_error_o);
    expect_low("ulpi_dir", i_ulpi_link_top.ulpi_dir);
    expect_low("ulpi_nxt", i_ulpi_link_top.ulpi_nxt);
    expect_low("ulpi_stp", i_ulpi_link_top.ulpi_stp);
    end_test("reset", mark);

    mark = errors;
    base = out_packets;
    repeat (NUM_PACKETS) begin
      build_packet(rand_range(1, MAX_LEN));
      tx_pkt = pkt_buf;
      send_tx(0);
      idle_gap();
    end
    drain();
    check_count("usb_out packets", NUM_PACKETS, out_packets - base);
    end_test("link to usb", mark);

    mark = errors;
    base = rx_packets;
    base_err = rx_errors;
    repeat (NUM_PACKETS) begin
      build_packet(rand_range(1, MAX_LEN));
      usb_pkt = pkt_buf;
      send_usb();
      idle_gap();
    end
    drain();
    check_count("rx packets", NUM_PACKETS, rx_packets - base);
    check_count("rx_error_o pulses", 0, rx_errors - base_err);
    end_test("usb to link", mark);

    mark = errors;
    repeat (NUM_GATED) begin
      drain();
      build_packet(rand_range(1, MAX_LEN));
      tx_pkt = pkt_buf;
      send_tx(rand_range(1, 8));
    end
    drain();
    end_test("start gating", mark);

    mark = errors;
    repeat (NUM_COLLIDE) begin
      build_packet(rand_range(1, MAX_LEN));
      tx_pkt = pkt_buf;
      build_packet(rand_range(1, MAX_LEN));
      usb_pkt = pkt_buf;
      fork
        send_tx(0);
        send_usb();
      join
      checks++;
      assert (out_last_cycle < usb_first_accept) else begin
        $display("ERROR t=%0t usb packet was taken before the link packet finished", $time);
        errors++;
      end
      idle_gap();
    end
    drain();
    end_test("collision", mark);

    mark = errors;
    base = rx_packets;
    base_err = rx_errors;
    build_packet(MAX_PACKET_BYTES + 4);
    usb_pkt = pkt_buf;
    send_usb();
    idle_gap();
    build_packet(rand_range(1, MAX_LEN));
    usb_pkt = pkt_buf;
    send_usb();
    drain();
    check_count("rx_error_o pulses", 1, rx_errors - base_err);
    check_count("rx packets", 1, rx_packets - base);
    end_test("overrun", mark);

    errors += i_ulpi_link_top.i_ulpi_phy_model.i_ulpi_link_properties.fail_count;
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- src.f
src/ulpi_pkg.sv
src/ulpi_link_tx.sv
src/ulpi_link_rx.sv
src/ulpi_phy_model.sv
src/ulpi_link_top.sv
tb/ulpi_link_properties.sv
tb/ulpi_link_tb.sv

//--- Bender.yml
package:
  name: ulpi_link

sources:
  - src/ulpi_pkg.sv
  - src/ulpi_link_tx.sv
  - src/ulpi_link_rx.sv
  - src/ulpi_phy_model.sv
  - src/ulpi_link_top.sv
  - target: test
    files:
      - tb/ulpi_link_properties.sv
      - tb/ulpi_link_tb.sv
